/* his_bank_ram.sv */
`timescale 1ns/1ns

module his_bank_ram
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 200,
    parameter int BIN_NUM   = 64,
    localparam int DEPTH    = PIXEL_NUM * BIN_NUM,
    localparam int ADDR_W   = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              inc_en,
    input  logic              inc_bank,
    input  pixel_t            inc_pixel,
    input  bin_t              inc_bin,
    input  logic              clr_en,
    input  logic              clr_bank,
    input  logic [ADDR_W-1:0] clr_addr,
    output count_t            clr_data
);

    // bank 0 in the lower half, bank 1 in the upper half
    count_t mem [2*DEPTH];

    logic [ADDR_W-1:0] inc_word;
    logic [ADDR_W:0]   inc_addr;
    logic [ADDR_W:0]   clr_idx;

    // increment pipeline, stage 1 holds the read value
    logic            s1_valid;
    logic [ADDR_W:0] s1_addr;
    count_t          s1_data;
    count_t          s1_next;
    logic            fwd;

    function automatic logic [ADDR_W:0] bank_addr(
        input logic              bank,
        input logic [ADDR_W-1:0] word
    );
        logic [ADDR_W:0] base;
        base = bank ? (ADDR_W+1)'(DEPTH) : '0;
        return base + {1'b0, word};
    endfunction

    // pixel-major layout
    assign inc_word = ADDR_W'(int'(inc_pixel) * BIN_NUM + int'(inc_bin));
    assign inc_addr = bank_addr(inc_bank, inc_word);
    assign clr_idx  = bank_addr(clr_bank, clr_addr);

    // saturating add
    assign s1_next = (s1_data == '1) ? s1_data : count_t'(s1_data + 1'b1);

    // same word again while stage 1 writes it
    assign fwd = inc_en && s1_valid && (s1_addr == inc_addr);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= inc_en;
        end
    end

    always_ff @(posedge clk) begin
        // read side of the increment
        if (inc_en) begin
            s1_addr <= inc_addr;
            s1_data <= fwd ? s1_next : mem[inc_addr];
        end
        // write side, one cycle after the read
        if (s1_valid) begin
            mem[s1_addr] <= s1_next;
        end
        // read-and-clear on the idle bank
        // never collides with the increment bank
        if (clr_en) begin
            clr_data     <= mem[clr_idx];
            mem[clr_idx] <= '0;
        end
    end

endmodule

/* his_ctrl.sv */
`timescale 1ns/1ns

module his_ctrl
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 200,
    parameter int DATA_NUM  = 4,
    parameter int ACQ_NUM   = 100,
    localparam int IN_W     = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1,
    localparam int ACQ_W    = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   run,
    input  logic   map_valid,
    input  logic   map_in_range,
    input  bin_t   map_bin,
    output logic   inc_en,
    output logic   inc_bank,
    output pixel_t inc_pixel,
    output bin_t   inc_bin,
    output logic   frame_done,
    output logic   rd_start,
    output logic   rd_bank
);

    his_state_t state;
    his_state_t state_nxt;

    logic [IN_W-1:0]  input_cnt;
    pixel_t           pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             bank;
    logic             settle_cnt;

    logic count_en;
    logic last_input;
    logic last_pixel;
    logic last_acq;
    logic frame_end;

    // hits count in accum and while settling
    assign count_en   = map_valid && (state != ST_IDLE);
    assign last_input = input_cnt == IN_W'(DATA_NUM - 1);
    assign last_pixel = pixel_cnt == PIX_W'(PIXEL_NUM - 1);
    assign last_acq   = acq_cnt == ACQ_W'(ACQ_NUM - 1);
    assign frame_end  = count_en && last_input && last_pixel && last_acq;

    // out-of-range hits advance counters but touch no bin
    assign inc_en     = count_en && map_in_range;
    assign inc_bank   = bank;
    assign inc_pixel  = pixel_cnt;
    assign inc_bin    = map_bin;
    assign frame_done = frame_end;
    // second settle cycle, last write has landed
    assign rd_start   = (state == ST_SETTLE) && settle_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (run) begin
                    state_nxt = ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (frame_end) begin
                    state_nxt = ST_SETTLE;
                end else if (!run) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_SETTLE: begin
                // readout launches, then back to counting or idle
                if (settle_cnt) begin
                    state_nxt = run ? ST_ACCUM : ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= ST_IDLE;
            settle_cnt <= 1'b0;
        end else begin
            state      <= state_nxt;
            settle_cnt <= (state == ST_SETTLE) && !settle_cnt;
        end
    end

    // nested input / pixel / acquisition counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (count_en) begin
            if (!last_input) begin
                input_cnt <= input_cnt + 1'b1;
            end else begin
                input_cnt <= '0;
                if (!last_pixel) begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end else begin
                    pixel_cnt <= '0;
                    acq_cnt   <= last_acq ? '0 : acq_cnt + 1'b1;
                end
            end
        end
    end

    // ping-pong toggle at frame end
    // finished bank held for the readout
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bank    <= 1'b0;
            rd_bank <= 1'b0;
        end else if (frame_end) begin
            bank    <= ~bank;
            rd_bank <= bank;
        end
    end

endmodule

/* his_readout.sv */
`timescale 1ns/1ns

module his_readout
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 200,
    parameter int BIN_NUM   = 64,
    localparam int ADDR_W   = $clog2(PIXEL_NUM * BIN_NUM)
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              rd_start,
    input  logic              rd_bank,
    input  count_t            clr_data,
    output logic              clr_en,
    output logic              clr_bank,
    output logic [ADDR_W-1:0] clr_addr,
    output logic              out_valid,
    output pixel_t            out_pixel,
    output bin_t              out_bin,
    output count_t            out_count,
    output logic              out_last
);

    logic              busy;
    logic [ADDR_W-1:0] addr_cnt;
    pixel_t            pix_cnt;
    bin_t              bin_cnt;
    logic              last_word;

    assign last_word = (pix_cnt == PIX_W'(PIXEL_NUM - 1)) && (bin_cnt == BIN_W'(BIN_NUM - 1));

    assign clr_en    = busy;
    assign clr_addr  = addr_cnt;
    // memory data already one cycle behind the address
    assign out_count = clr_data;

    // address walk, one word per cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            clr_bank <= 1'b0;
            addr_cnt <= '0;
            pix_cnt  <= '0;
            bin_cnt  <= '0;
        end else if (rd_start) begin
            busy     <= 1'b1;
            clr_bank <= rd_bank;
            addr_cnt <= '0;
            pix_cnt  <= '0;
            bin_cnt  <= '0;
        end else if (busy) begin
            addr_cnt <= addr_cnt + 1'b1;
            if (last_word) begin
                busy <= 1'b0;
            end
            // bins ascending inside each pixel
            if (bin_cnt == BIN_W'(BIN_NUM - 1)) begin
                bin_cnt <= '0;
                pix_cnt <= pix_cnt + 1'b1;
            end else begin
                bin_cnt <= bin_cnt + 1'b1;
            end
        end
    end

    // flags lined up with clr_data
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= busy;
            out_last  <= busy && last_word;
        end
    end

    // tags lined up with clr_data
    always_ff @(posedge clk) begin
        out_pixel <= pix_cnt;
        out_bin   <= bin_cnt;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the histogram testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sifh.f --top-module sifh_tb -o sifh_sim

sim_out=$(./obj_dir/sifh_sim 2>&1 || true)
echo "$sim_out"

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* sifh.f */
sifh_pkg.sv
tdc_bin_mapper.sv
his_ctrl.sv
his_bank_ram.sv
his_readout.sv
sifh_top.sv
sifh_sva.sv
sifh_tb.sv

/* sifh_cases.txt */
// per frame: number of listed bins, then 64 hit timestamps (8 per line,
// one pixel of one acquisition per line), then the listed non-zero bins
// as pixel[31:24] bin[23:16] count[15:0]; window 0x10..0x2f, 4 ticks per bin
// frame 1: mapping, out-of-range and back-to-back hits
00000011
0010 0010 0010 0014 0018 001c 0020 0005
0024 0028 002c 002f 0030 ffff 0011 0013
001a 001a 001a 001a 000f 0040 0021 0022
0017 0016 0015 0014 0027 0026 0025 0024
0010 0013 0012 0011 002e 002e 1234 0000
0000 0000 0000 0000 0000 0000 0000 0000
001c 001d 001e 001f 0020 0028 0029 002a
0019 0019 0019 0019 0019 0019 0019 0019
00000007 00010001 00020001 00030001
00040001 00070002 01000002 01050001
01060001 01070002 02020004 02030004
02040003 02060003 03010004 03020008
03050004
// frame 2: counted into bank 1, nothing of frame 1 may show
0000000f
002c 002c 002c 002c 002c 002c 002c 002c
0030 0031 0032 0033 0034 0035 0036 0037
0010 0014 0018 001c 0020 0024 0028 002c
0003 0003 0003 0003 0003 0003 0003 0003
0013 0013 0017 0017 001b 001b 001f 001f
0026 0026 0026 0026 0026 0026 0026 0026
002f 002e 002d 002c 0023 0022 0021 0020
8000 0001 0010 0010 0010 ffff 0010 0010
00000002 00010002 00020002 00030002
00070008 01050008 02000001 02010001
02020001 02030001 02040005 02050001
02060001 02070005 03000005
// frame 3: bank 0 again, sparse so leftovers would stand out
00000005
0012 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0015
0000 0000 0000 0000 0000 0000 0000 0000
002a 002a 002a 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
001e 001e 001e 001e 0000 0000 0000 0000
0020 ffff 0020 ffff 0020 ffff 0020 ffff
0000 0000 0000 0000 0000 0000 0000 0000
00000001 01010001 01030004 02040004
03060003

/* sifh_pkg.sv */
package sifh_pkg;

    // timestamp from the tdc
    localparam int TIME_W  = 16;
    // bin index, up to 64 bins per pixel
    localparam int BIN_W   = 6;
    // pixel index
    localparam int PIX_W   = 8;
    // histogram word
    localparam int COUNT_W = 16;

    typedef logic [TIME_W-1:0]  time_t;
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [PIX_W-1:0]   pixel_t;
    // saturates at all ones
    typedef logic [COUNT_W-1:0] count_t;

    // control fsm states
    // settle covers the last write before readout
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCUM,
        ST_SETTLE
    } his_state_t;

endpackage

/* sifh_sva.sv */
`timescale 1ns/1ns

module sifh_sva #(
    parameter int WORDS = 32
) (
    input logic clk,
    input logic combin_res,
    input logic frame_done,
    input logic rd_start,
    input logic out_valid
);

    // cycles out_valid has been high so far
    int run_len;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            run_len <= 0;
        end else if (out_valid) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    // readout launch exactly two cycles after the frame end
    launch_after_done: assert property (@(posedge clk) disable iff (!combin_res)
        $past(frame_done, 2) |-> rd_start)
        else $error("rd_start missing two cycles after frame_done");

    launch_only_after_done: assert property (@(posedge clk) disable iff (!combin_res)
        rd_start |-> $past(frame_done, 2))
        else $error("rd_start without frame_done two cycles before");

    // stream never longer than one bank
    stream_not_long: assert property (@(posedge clk) disable iff (!combin_res)
        out_valid |-> run_len < WORDS)
        else $error("out_valid high for more than one bank of words");

    // and never cut short
    stream_full_len: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(out_valid) |-> run_len == WORDS)
        else $error("out_valid dropped before a full bank was streamed");

    // no relaunch over a running stream
    no_start_in_stream: assert property (@(posedge clk) disable iff (!combin_res)
        rd_start |-> !out_valid)
        else $error("rd_start while the stream is still running");

endmodule

// wires between his_ctrl and his_readout live in the top level
bind sifh_top sifh_sva #(
    .WORDS (PIXEL_NUM * BIN_NUM)
) sifh_sva_i (
    .clk        (clk),
    .combin_res (combin_res),
    .frame_done (frame_done),
    .rd_start   (rd_start),
    .out_valid  (out_valid)
);

/* sifh_tb.sv */
`timescale 1ns/1ns

module sifh_tb
    import sifh_pkg::*;
();

    localparam int PIXEL_NUM   = 4;
    localparam int DATA_NUM    = 8;
    localparam int ACQ_NUM     = 2;
    localparam int BIN_NUM     = 8;
    localparam int TIME_OFFSET = 16;
    localparam int BIN_SHIFT   = 2;

    localparam int FRAME_NUM = 3;
    // hits per acquisition and per frame
    localparam int ACQ_HITS  = PIXEL_NUM * DATA_NUM;
    localparam int HITS      = ACQ_HITS * ACQ_NUM;
    // stream words per frame
    localparam int WORDS     = PIXEL_NUM * BIN_NUM;
    // up to 4 cycles per hit, about 40 per readout, plus margin
    localparam int TIMEOUT_CYCLES = FRAME_NUM * HITS * 4 + FRAME_NUM * 40 + 200;

    logic   clk = 1'b0;
    logic   combin_res;
    logic   run;
    logic   hit_valid;
    time_t  hit_time;
    logic   frame_done;
    logic   out_valid;
    pixel_t out_pixel;
    bin_t   out_bin;
    count_t out_count;
    logic   out_last;

    // raw words of the case file
    logic [31:0] case_mem [256];
    int hit_list [FRAME_NUM][HITS];
    // counts listed in the file, unlisted bins stay zero
    int listed   [FRAME_NUM][WORDS];
    // own histogram model, built while driving
    int model    [FRAME_NUM][WORDS];

    integer seed;
    int     error_cnt    = 0;
    int     check_cnt    = 0;
    int     test_cnt     = 0;
    int     cycle_cnt    = 0;
    int     stream_frame = 0;
    int     stream_idx   = 0;
    int     stream_err0  = 0;

    sifh_top #(
        .PIXEL_NUM   (PIXEL_NUM),
        .DATA_NUM    (DATA_NUM),
        .ACQ_NUM     (ACQ_NUM),
        .BIN_NUM     (BIN_NUM),
        .TIME_OFFSET (TIME_OFFSET),
        .BIN_SHIFT   (BIN_SHIFT)
    ) sifh_top_i (
        .clk        (clk),
        .combin_res (combin_res),
        .run        (run),
        .hit_valid  (hit_valid),
        .hit_time   (hit_time),
        .frame_done (frame_done),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last)
    );

    always #10 clk = ~clk;

    // hard stop
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the readout streams did not all complete",
                     TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // bin index by the timing rule, -1 outside the window
    function automatic int map_hit(input int t);
        int rel;
        rel = t - TIME_OFFSET;
        if (rel < 0 || (rel >> BIN_SHIFT) >= BIN_NUM) begin
            return -1;
        end
        return rel >> BIN_SHIFT;
    endfunction

    task automatic report_test(input string name, input int err0);
        test_cnt++;
        if (error_cnt == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_cnt - err0);
        end
    endtask

    task automatic check_quiet(input string where);
        check_cnt++;
        assert (!frame_done && !out_valid && !out_last) else begin
            $display("Mismatch at %0t ns: %s, frame_done %0b out_valid %0b out_last %0b",
                     $time, where, frame_done, out_valid, out_last);
            error_cnt++;
        end
    endtask

    // header word, 64 timestamps, then pixel/bin/count words per frame
    task automatic load_cases();
        int ptr;
        int f;
        int i;
        int n;
        int idx;
        ptr = 0;
        $readmemh("sifh_cases.txt", case_mem);
        for (f = 0; f < FRAME_NUM; f++) begin
            n = int'(case_mem[ptr]);
            ptr++;
            if (n == 0 || n > WORDS) begin
                $display("case file sifh_cases.txt is missing or frame %0d has a bad bin count",
                         f + 1);
                error_cnt++;
                n = 0;
            end
            for (i = 0; i < HITS; i++) begin
                hit_list[f][i] = int'(case_mem[ptr][15:0]);
                ptr++;
            end
            for (i = 0; i < n; i++) begin
                idx = int'(case_mem[ptr][31:24]) * BIN_NUM + int'(case_mem[ptr][23:16]);
                if (idx < WORDS) begin
                    listed[f][idx] = int'(case_mem[ptr][15:0]);
                end else begin
                    $display("case file entry %0d of frame %0d names a bin outside the memory",
                             i, f + 1);
                    error_cnt++;
                end
                ptr++;
            end
        end
    endtask

    // one frame of hits, starts and ends on a falling edge
    task automatic drive_frame(input int f);
        int k;
        int t;
        int b;
        int pix;
        int gap;
        int err0;
        err0 = error_cnt;
        for (k = 0; k < HITS; k++) begin
            t   = hit_list[f][k];
            b   = map_hit(t);
            pix = (k % ACQ_HITS) / DATA_NUM;
            if (b >= 0) begin
                model[f][pix * BIN_NUM + b]++;
            end
            hit_valid = 1'b1;
            hit_time  = time_t'(t);
            @(negedge clk);
            hit_valid = 1'b0;
            // pulse rides with the mapped last hit only
            check_cnt++;
            assert (frame_done == (k == HITS - 1)) else begin
                $display("Mismatch at %0t ns: frame %0d hit %0d frame_done %0b",
                         $time, f + 1, k, frame_done);
                error_cnt++;
            end
            // same bin again goes back to back, hits the forwarding path
            if (k < HITS - 1 && b >= 0 && map_hit(hit_list[f][k + 1]) == b) begin
                gap = 0;
            end else begin
                gap = $random(seed) & 3;
            end
            repeat (gap) begin
                @(negedge clk);
                check_cnt++;
                assert (!frame_done) else begin
                    $display("Mismatch at %0t ns: frame %0d frame_done high in a gap",
                             $time, f + 1);
                    error_cnt++;
                end
            end
        end
        report_test($sformatf("frame %0d hits", f + 1), err0);
    endtask

    // one stream word, tags and counts against file and model
    task automatic check_word();
        int exp_pix;
        int exp_bin;
        exp_pix = stream_idx / BIN_NUM;
        exp_bin = stream_idx % BIN_NUM;
        if (stream_frame >= FRAME_NUM || stream_idx >= WORDS) begin
            $display("stream word at %0t ns lies outside the %0d expected frames of %0d words",
                     $time, FRAME_NUM, WORDS);
            error_cnt++;
        end else begin
            if (stream_idx == 0) begin
                stream_err0 = error_cnt;
            end
            check_cnt += 4;
            assert (out_pixel == pixel_t'(exp_pix) && out_bin == bin_t'(exp_bin)) else begin
                $display("Mismatch at %0t ns: frame %0d word %0d tag %0d/%0d, expected %0d/%0d",
                         $time, stream_frame + 1, stream_idx, out_pixel, out_bin,
                         exp_pix, exp_bin);
                error_cnt++;
            end
            assert (int'(out_count) == model[stream_frame][stream_idx]) else begin
                $display("Mismatch at %0t ns: frame %0d word %0d count %0d, model %0d",
                         $time, stream_frame + 1, stream_idx, out_count,
                         model[stream_frame][stream_idx]);
                error_cnt++;
            end
            assert (int'(out_count) == listed[stream_frame][stream_idx]) else begin
                $display("Mismatch at %0t ns: frame %0d word %0d count %0d, case file %0d",
                         $time, stream_frame + 1, stream_idx, out_count,
                         listed[stream_frame][stream_idx]);
                error_cnt++;
            end
            assert (out_last == (stream_idx == WORDS - 1)) else begin
                $display("Mismatch at %0t ns: frame %0d word %0d out_last %0b",
                         $time, stream_frame + 1, stream_idx, out_last);
                error_cnt++;
            end
            stream_idx++;
        end
        if (out_last) begin
            if (stream_frame < FRAME_NUM) begin
                report_test($sformatf("frame %0d readout", stream_frame + 1), stream_err0);
            end
            stream_frame++;
            stream_idx = 0;
        end
    endtask

    // outputs change on the rising edge, sampled on the falling one
    always @(negedge clk) begin
        if (combin_res && out_valid) begin
            check_word();
        end
    end

    initial begin
        int i;
        int err0;
        combin_res = 1'b0;
        run        = 1'b0;
        hit_valid  = 1'b0;
        hit_time   = '0;
        seed       = 32'hcbba5386;
        load_cases();

        // reset held for 5 cycles
        err0 = error_cnt;
        repeat (5) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        combin_res = 1'b1;

        // hits with run low must leave no trace in frame 1
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            check_quiet("idle after reset");
            hit_valid = 1'b1;
            hit_time  = time_t'(TIME_OFFSET + 4 * i);
        end
        @(negedge clk);
        hit_valid = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_quiet("idle after reset");
        end
        report_test("reset and idle", err0);

        run = 1'b1;
        @(negedge clk);
        for (i = 0; i < FRAME_NUM; i++) begin
            drive_frame(i);
        end

        wait (stream_frame == FRAME_NUM);
        repeat (3) begin
            @(negedge clk);
            check_quiet("after the last readout");
        end

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sifh_top.sv */
`timescale 1ns/1ns

module sifh_top
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM   = 200,
    parameter int DATA_NUM    = 4,
    parameter int ACQ_NUM     = 100,
    parameter int BIN_NUM     = 64,
    parameter int TIME_OFFSET = 0,
    parameter int BIN_SHIFT   = 2,
    localparam int ADDR_W     = $clog2(PIXEL_NUM * BIN_NUM)
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   run,
    input  logic   hit_valid,
    input  time_t  hit_time,
    output logic   frame_done,
    output logic   out_valid,
    output pixel_t out_pixel,
    output bin_t   out_bin,
    output count_t out_count,
    output logic   out_last
);

    // mapper to control
    logic map_valid;
    bin_t map_bin;
    logic map_in_range;

    // control to memory
    logic   inc_en;
    logic   inc_bank;
    pixel_t inc_pixel;
    bin_t   inc_bin;

    // control to readout
    logic rd_start;
    logic rd_bank;

    // readout to memory and back
    logic              clr_en;
    logic              clr_bank;
    logic [ADDR_W-1:0] clr_addr;
    count_t            clr_data;

    tdc_bin_mapper #(
        .TIME_OFFSET (TIME_OFFSET),
        .BIN_SHIFT   (BIN_SHIFT),
        .BIN_NUM     (BIN_NUM)
    ) tdc_bin_mapper_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .hit_valid    (hit_valid),
        .hit_time     (hit_time),
        .map_valid    (map_valid),
        .map_bin      (map_bin),
        .map_in_range (map_in_range)
    );

    his_ctrl #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) his_ctrl_i (
        .clk          (clk),
        .combin_res   (combin_res),
        .run          (run),
        .map_valid    (map_valid),
        .map_in_range (map_in_range),
        .map_bin      (map_bin),
        .inc_en       (inc_en),
        .inc_bank     (inc_bank),
        .inc_pixel    (inc_pixel),
        .inc_bin      (inc_bin),
        .frame_done   (frame_done),
        .rd_start     (rd_start),
        .rd_bank      (rd_bank)
    );

    his_bank_ram #(
        .PIXEL_NUM (PIXEL_NUM),
        .BIN_NUM   (BIN_NUM)
    ) his_bank_ram_i (
        .clk        (clk),
        .combin_res (combin_res),
        .inc_en     (inc_en),
        .inc_bank   (inc_bank),
        .inc_pixel  (inc_pixel),
        .inc_bin    (inc_bin),
        .clr_en     (clr_en),
        .clr_bank   (clr_bank),
        .clr_addr   (clr_addr),
        .clr_data   (clr_data)
    );

    his_readout #(
        .PIXEL_NUM (PIXEL_NUM),
        .BIN_NUM   (BIN_NUM)
    ) his_readout_i (
        .clk        (clk),
        .combin_res (combin_res),
        .rd_start   (rd_start),
        .rd_bank    (rd_bank),
        .clr_data   (clr_data),
        .clr_en     (clr_en),
        .clr_bank   (clr_bank),
        .clr_addr   (clr_addr),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count),
        .out_last   (out_last)
    );

endmodule

/* tdc_bin_mapper.sv */
`timescale 1ns/1ns

module tdc_bin_mapper
    import sifh_pkg::*;
#(
    parameter int TIME_OFFSET = 0,
    parameter int BIN_SHIFT   = 2,
    parameter int BIN_NUM     = 64
) (
    input  logic  clk,
    input  logic  combin_res,
    input  logic  hit_valid,
    input  time_t hit_time,
    output logic  map_valid,
    output bin_t  map_bin,
    output logic  map_in_range
);

    time_t rel_time;
    time_t bin_idx;
    logic  early;
    logic  in_range;

    // hit before the window start
    assign early    = hit_time < TIME_W'(TIME_OFFSET);
    assign rel_time = hit_time - TIME_W'(TIME_OFFSET);
    // bin width is 2**BIN_SHIFT ticks
    assign bin_idx  = rel_time >> BIN_SHIFT;
    assign in_range = !early && (bin_idx < TIME_W'(BIN_NUM));

    // strobe delayed by one cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= hit_valid;
        end
    end

    // tags only meaningful with map_valid
    always_ff @(posedge clk) begin
        map_bin      <= bin_idx[BIN_W-1:0];
        map_in_range <= in_range;
    end

endmodule
